// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_mini_mcu -o tb_mini_mcu
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/tb_mini_mcu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: source/gpio_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// GPIO registers, two-flop input synchronizer, rising-edge interrupts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl #(
  parameter int NUM_GPIO = 8
) (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                sel_i,
  input  wire logic                we_i,
  input  wire logic [7:0]          offset_i,
  input  wire mcu_pkg::data_t      wdata_i,
  output mcu_pkg::data_t           rdata_o,
  input  wire logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0]      gpio_o,
  output logic [NUM_GPIO-1:0]      gpio_oe_o,
  output logic [NUM_GPIO-1:0]      gpio_intr_o
);

  import mcu_pkg::*;

  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] oe_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] status_q;
  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] clr;
  logic                wr;

  assign wr = sel_i & we_i;

  // edge seen as the value moves into the second stage
  assign rise = sync1_q & ~sync2_q;
  assign clr  = (wr && offset_i == GPIO_INTR_STATUS) ? wdata_i[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      // a new edge beats a clear in the same cycle
      status_q <= (status_q & ~clr) | (rise & intr_en_q);
      if (wr) begin
        case (offset_i)
          GPIO_OUT:     out_q     <= wdata_i[NUM_GPIO-1:0];
          GPIO_OE:      oe_q      <= wdata_i[NUM_GPIO-1:0];
          GPIO_INTR_EN: intr_en_q <= wdata_i[NUM_GPIO-1:0];
          default:      ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset_i)
      GPIO_OUT:         rdata_o = data_t'(out_q);
      GPIO_OE:          rdata_o = data_t'(oe_q);
      GPIO_IN:          rdata_o = data_t'(sync2_q);
      GPIO_INTR_EN:     rdata_o = data_t'(intr_en_q);
      GPIO_INTR_STATUS: rdata_o = data_t'(status_q);
      default:          rdata_o = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_intr_o = status_q & intr_en_q;

endmodule

`default_nettype wire

// File: source/irq_router.sv
////////////////////////////////////////////////////////////////////////////
// Software interrupt register and registered interrupt vector
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module irq_router #(
  parameter int NUM_GPIO = 8
) (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                sel_i,
  input  wire logic                we_i,
  input  wire logic [7:0]          offset_i,
  input  wire mcu_pkg::data_t      wdata_i,
  output mcu_pkg::data_t           rdata_o,
  input  wire logic                timer_intr_i,
  input  wire logic                ext_irq_i,
  input  wire logic [NUM_GPIO-1:0] gpio_intr_i,
  output logic [31:0]              irq_o
);

  import mcu_pkg::*;

  logic        msip_q;
  logic [31:0] vec;

  always_comb begin
    vec                = '0;
    vec[IRQ_SW_BIT]    = msip_q;
    vec[IRQ_TIMER_BIT] = timer_intr_i;
    vec[IRQ_EXT_BIT]   = ext_irq_i;
    // gpio pins sit in the fast field
    for (int k = 0; k < NUM_GPIO; k++) begin
      vec[IRQ_FAST_BASE + FAST_GPIO_OFS + k] = gpio_intr_i[k];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      msip_q <= 1'b0;
      irq_o  <= '0;
    end else begin
      irq_o <= vec;
      if (sel_i && we_i && offset_i == IRQ_MSIP) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  assign rdata_o = (offset_i == IRQ_MSIP)   ? data_t'(msip_q) :
                   (offset_i == IRQ_VECTOR) ? data_t'(irq_o)  : '0;

endmodule

`default_nettype wire

// File: source/machine_timer.sv
////////////////////////////////////////////////////////////////////////////
// Machine timer with loadable time counter and compare interrupt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module machine_timer (
  input  wire logic           clk_i,
  input  wire logic           rst_i,
  input  wire logic           sel_i,
  input  wire logic           we_i,
  input  wire logic [7:0]     offset_i,
  input  wire mcu_pkg::data_t wdata_i,
  output mcu_pkg::data_t      rdata_o,
  output logic                timer_intr_o
);

  import mcu_pkg::*;

  data_t time_q;
  data_t cmp_q;
  logic  en_q;
  logic  wr;

  assign wr = sel_i & we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      time_q <= '0;
      cmp_q  <= '0;
      en_q   <= 1'b0;
    end else begin
      // a write to time overrides the increment
      if (wr && offset_i == TMR_TIME) begin
        time_q <= wdata_i;
      end else if (en_q) begin
        time_q <= time_q + 1'b1;
      end
      if (wr && offset_i == TMR_CMP) begin
        cmp_q <= wdata_i;
      end
      if (wr && offset_i == TMR_CTRL) begin
        en_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      TMR_TIME: rdata_o = time_q;
      TMR_CMP:  rdata_o = cmp_q;
      TMR_CTRL: rdata_o = data_t'(en_q);
      default:  rdata_o = '0;
    endcase
  end

  // level, held until compare moves or counting stops
  assign timer_intr_o = en_q && (time_q >= cmp_q);

endmodule

`default_nettype wire

// File: source/mcu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Bus widths, block address map, register offsets, interrupt bit
// positions and power manager state codes
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mcu_pkg;

  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // block bases, address bits 9:8 select the block
  localparam addr_t BLK_GPIO  = 12'h000;
  localparam addr_t BLK_TIMER = 12'h100;
  localparam addr_t BLK_IRQ   = 12'h200;
  localparam addr_t BLK_PWR   = 12'h300;

  // gpio registers
  localparam logic [7:0] GPIO_OUT         = 8'h00;
  localparam logic [7:0] GPIO_OE          = 8'h04;
  localparam logic [7:0] GPIO_IN          = 8'h08;
  localparam logic [7:0] GPIO_INTR_EN     = 8'h0C;
  localparam logic [7:0] GPIO_INTR_STATUS = 8'h10;

  // machine timer registers
  localparam logic [7:0] TMR_TIME = 8'h00;
  localparam logic [7:0] TMR_CMP  = 8'h04;
  localparam logic [7:0] TMR_CTRL = 8'h08;

  // interrupt router registers
  localparam logic [7:0] IRQ_MSIP   = 8'h00;
  localparam logic [7:0] IRQ_VECTOR = 8'h04;

  // power manager registers
  localparam logic [7:0] PWR_CTRL  = 8'h00;
  localparam logic [7:0] PWR_STATE = 8'h04;

  // positions in the core interrupt vector
  localparam int IRQ_SW_BIT    = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXT_BIT   = 11;
  localparam int IRQ_FAST_BASE = 16;
  localparam int FAST_GPIO_OFS = 6;

  typedef enum logic [2:0] {
    PWR_ON     = 3'd0,
    PWR_RST    = 3'd1,
    PWR_ISO    = 3'd2,
    PWR_SW_OFF = 3'd3,
    PWR_OFF    = 3'd4,
    PWR_SW_ON  = 3'd5,
    PWR_DEISO  = 3'd6
  } pwr_state_t;

endpackage

`default_nettype wire

// File: source/mini_mcu_top.sv
////////////////////////////////////////////////////////////////////////////
// Always-on MCU top: bus decoder, GPIO, timer, interrupts, power manager
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mini_mcu_top #(
  parameter int NUM_GPIO = 8
) (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                req_i,
  input  wire logic                we_i,
  input  wire mcu_pkg::addr_t      addr_i,
  input  wire mcu_pkg::data_t      wdata_i,
  output mcu_pkg::data_t           rdata_o,
  output logic                     rvalid_o,
  input  wire logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0]      gpio_o,
  output logic [NUM_GPIO-1:0]      gpio_oe_o,
  input  wire logic                ext_irq_i,
  output logic [31:0]              irq_o,
  input  wire logic                core_sleep_i,
  output logic                     cpu_switch_o,
  input  wire logic                cpu_switch_ack_i,
  output logic                     cpu_iso_o,
  output logic                     cpu_rst_o
);

  import mcu_pkg::*;

  logic [3:0]          blk_sel;
  logic                blk_we;
  logic [7:0]          blk_offset;
  data_t               blk_wdata;
  data_t               rd_gpio;
  data_t               rd_timer;
  data_t               rd_irq;
  data_t               rd_pwr;
  logic [NUM_GPIO-1:0] gpio_intr;
  logic                timer_intr;

  reg_bus_decoder reg_bus_decoder_i (
    .clk_i, .rst_i, .req_i, .we_i, .addr_i, .wdata_i, .rdata_o, .rvalid_o,
    .sel_o(blk_sel), .we_o(blk_we), .offset_o(blk_offset), .wdata_o(blk_wdata),
    .rd_gpio_i(rd_gpio), .rd_timer_i(rd_timer), .rd_irq_i(rd_irq), .rd_pwr_i(rd_pwr)
  );

  gpio_ctrl #(.NUM_GPIO(NUM_GPIO)) gpio_ctrl_i (
    .clk_i, .rst_i, .sel_i(blk_sel[BLK_GPIO[9:8]]), .we_i(blk_we),
    .offset_i(blk_offset), .wdata_i(blk_wdata), .rdata_o(rd_gpio),
    .gpio_i, .gpio_o, .gpio_oe_o, .gpio_intr_o(gpio_intr)
  );

  machine_timer machine_timer_i (
    .clk_i, .rst_i, .sel_i(blk_sel[BLK_TIMER[9:8]]), .we_i(blk_we),
    .offset_i(blk_offset), .wdata_i(blk_wdata), .rdata_o(rd_timer),
    .timer_intr_o(timer_intr)
  );

  irq_router #(.NUM_GPIO(NUM_GPIO)) irq_router_i (
    .clk_i, .rst_i, .sel_i(blk_sel[BLK_IRQ[9:8]]), .we_i(blk_we),
    .offset_i(blk_offset), .wdata_i(blk_wdata), .rdata_o(rd_irq),
    .timer_intr_i(timer_intr), .ext_irq_i, .gpio_intr_i(gpio_intr), .irq_o
  );

  // wakes the cpu domain on any pending interrupt
  power_manager power_manager_i (
    .clk_i, .rst_i, .sel_i(blk_sel[BLK_PWR[9:8]]), .we_i(blk_we),
    .offset_i(blk_offset), .wdata_i(blk_wdata), .rdata_o(rd_pwr),
    .core_sleep_i, .irq_i(irq_o), .cpu_switch_o, .cpu_switch_ack_i,
    .cpu_iso_o, .cpu_rst_o
  );

endmodule

`default_nettype wire

// File: source/power_manager.sv
////////////////////////////////////////////////////////////////////////////
// CPU domain power sequencer: reset, isolation and power switch control
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module power_manager (
  input  wire logic           clk_i,
  input  wire logic           rst_i,
  input  wire logic           sel_i,
  input  wire logic           we_i,
  input  wire logic [7:0]     offset_i,
  input  wire mcu_pkg::data_t wdata_i,
  output mcu_pkg::data_t      rdata_o,
  input  wire logic           core_sleep_i,
  input  wire logic [31:0]    irq_i,
  output logic                cpu_switch_o,
  input  wire logic           cpu_switch_ack_i,
  output logic                cpu_iso_o,
  output logic                cpu_rst_o
);

  import mcu_pkg::*;

  pwr_state_t state_q;
  pwr_state_t state_d;
  logic       pd_req;

  // only honoured while running and the core is asleep
  assign pd_req = sel_i && we_i && offset_i == PWR_CTRL && wdata_i[0] && core_sleep_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ON:     if (pd_req) state_d = PWR_RST;
      PWR_RST:    state_d = PWR_ISO;
      PWR_ISO:    state_d = PWR_SW_OFF;
      PWR_SW_OFF: if (!cpu_switch_ack_i) state_d = PWR_OFF;
      PWR_OFF:    if (|irq_i) state_d = PWR_SW_ON;
      PWR_SW_ON:  if (cpu_switch_ack_i) state_d = PWR_DEISO;
      PWR_DEISO:  state_d = PWR_ON;
      default:    state_d = PWR_ON;
    endcase
  end

  // outputs follow the state they belong to in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= PWR_ON;
      cpu_switch_o <= 1'b1;
      cpu_iso_o    <= 1'b0;
      cpu_rst_o    <= 1'b0;
    end else begin
      state_q      <= state_d;
      cpu_rst_o    <= (state_d != PWR_ON);
      cpu_iso_o    <= (state_d == PWR_ISO) || (state_d == PWR_SW_OFF) ||
                      (state_d == PWR_OFF) || (state_d == PWR_SW_ON);
      cpu_switch_o <= (state_d != PWR_SW_OFF) && (state_d != PWR_OFF);
    end
  end

  always_comb begin
    case (offset_i)
      PWR_STATE: rdata_o = data_t'(state_q);
      default:   rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/reg_bus_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Register bus decoder with one-cycle registered read return
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module reg_bus_decoder (
  input  wire logic           clk_i,
  input  wire logic           rst_i,
  input  wire logic           req_i,
  input  wire logic           we_i,
  input  wire mcu_pkg::addr_t addr_i,
  input  wire mcu_pkg::data_t wdata_i,
  output mcu_pkg::data_t      rdata_o,
  output logic                rvalid_o,
  output logic [3:0]          sel_o,
  output logic                we_o,
  output logic [7:0]          offset_o,
  output mcu_pkg::data_t      wdata_o,
  input  wire mcu_pkg::data_t rd_gpio_i,
  input  wire mcu_pkg::data_t rd_timer_i,
  input  wire mcu_pkg::data_t rd_irq_i,
  input  wire mcu_pkg::data_t rd_pwr_i
);

  import mcu_pkg::*;

  data_t rd_mux;
  logic  rd_req;

  assign rd_req   = req_i & ~we_i;
  assign we_o     = we_i;
  assign offset_o = addr_i[7:0];
  assign wdata_o  = wdata_i;

  // one-hot strobe, bit index is address bits 9:8
  always_comb begin
    sel_o = '0;
    if (req_i) begin
      sel_o[addr_i[9:8]] = 1'b1;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (addr_i[9:8])
      BLK_GPIO[9:8]:  rd_mux = rd_gpio_i;
      BLK_TIMER[9:8]: rd_mux = rd_timer_i;
      BLK_IRQ[9:8]:   rd_mux = rd_irq_i;
      BLK_PWR[9:8]:   rd_mux = rd_pwr_i;
      default:        rd_mux = '0;
    endcase
  end

  // data sampled before any write of the same edge lands
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= rd_req;
      rdata_o  <= rd_req ? rd_mux : '0;
    end
  end

endmodule

`default_nettype wire

// File: src.f
source/mcu_pkg.sv
source/reg_bus_decoder.sv
source/gpio_ctrl.sv
source/machine_timer.sv
source/irq_router.sv
source/power_manager.sv
source/mini_mcu_top.sv
verification/tb_mini_mcu.sv

// File: verification/tb_mini_mcu.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for mini_mcu_top: random bus traffic, register model, switch
// acknowledge model and checks on reads, pads, interrupts and power states
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu;

  import mcu_pkg::*;

  localparam int NUM_GPIO = 8;
  // all phases together take well under 1000 cycles
  localparam int MAX_CYCLES = 4000;

  logic                clk;
  logic                rst;
  logic                req;
  logic                we;
  addr_t               addr;
  data_t               wdata;
  data_t               rdata;
  logic                rvalid;
  logic [NUM_GPIO-1:0] gpio_in;
  logic [NUM_GPIO-1:0] gpio_out;
  logic [NUM_GPIO-1:0] gpio_oe;
  logic                ext_irq;
  logic [31:0]         irq;
  logic                core_sleep;
  logic                cpu_switch;
  logic                cpu_switch_ack = 1'b1;
  logic                cpu_iso;
  logic                cpu_rst;

  integer seed = 72502;
  integer ack_seed = 72502;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     ack_wait = 0;

  // register model
  logic [NUM_GPIO-1:0] m_out;
  logic [NUM_GPIO-1:0] m_oe;
  logic [NUM_GPIO-1:0] m_en;
  logic [NUM_GPIO-1:0] m_status;
  logic [NUM_GPIO-1:0] m_prev;
  logic                m_msip;
  logic                m_ext;

  data_t               d;
  data_t               t;
  data_t               t_prev;
  logic [NUM_GPIO-1:0] v;
  int                  c;
  int                  n;
  int                  sw_at;
  int                  iso_at;
  int                  rst_at;

  mini_mcu_top #(.NUM_GPIO(NUM_GPIO)) UUT (
    .clk_i(clk), .rst_i(rst), .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata),
    .rdata_o(rdata), .rvalid_o(rvalid), .gpio_i(gpio_in), .gpio_o(gpio_out),
    .gpio_oe_o(gpio_oe), .ext_irq_i(ext_irq), .irq_o(irq), .core_sleep_i(core_sleep),
    .cpu_switch_o(cpu_switch), .cpu_switch_ack_i(cpu_switch_ack), .cpu_iso_o(cpu_iso),
    .cpu_rst_o(cpu_rst)
  );

  always #4 clk = ~clk;

  // power switch answers after 1 to 8 cycles
  always @(posedge clk) begin
    if (rst) begin
      cpu_switch_ack <= 1'b1;
      ack_wait       <= 0;
    end else if (cpu_switch != cpu_switch_ack) begin
      if (ack_wait == 0) begin
        ack_wait <= 1 + int'({$random(ack_seed)} % 8);
      end else if (ack_wait == 1) begin
        cpu_switch_ack <= cpu_switch;
        ack_wait       <= 0;
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("sim failed");
      $finish;
    end
  end

  function automatic addr_t reg_addr(input addr_t base, input logic [7:0] ofs);
    return {base[11:8], ofs};
  endfunction

  // sw 3, timer 7, ext 11, gpio pins from 22
  function automatic logic [31:0] expected_irq();
    logic [31:0] vec;
    vec                 = '0;
    vec[3]              = m_msip;
    vec[11]             = m_ext;
    vec[22 +: NUM_GPIO] = m_status & m_en;
    return vec;
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_irq(input string name);
    check_value(name, expected_irq(), irq);
  endtask

  task automatic wait_cycles(input int num);
    repeat (num) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic bus_write(input addr_t a, input data_t wd);
    @(posedge clk);
    req   <= 1'b1;
    we    <= 1'b1;
    addr  <= a;
    wdata <= wd;
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic bus_read(input addr_t a, output data_t rd);
    @(posedge clk);
    req  <= 1'b1;
    we   <= 1'b0;
    addr <= a;
    @(negedge clk);
    checks++;
    assert (!rvalid) else begin
      errors++;
      $display("rvalid_o came early, in the request cycle of read %h", a);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    checks++;
    assert (rvalid) else begin
      errors++;
      $display("rvalid_o missing one cycle after read of %h", a);
    end
    rd = rdata;
  endtask

  task automatic read_check(input string name, input addr_t a, input data_t exp);
    data_t rd;
    bus_read(a, rd);
    check_value(name, exp, rd);
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    gpio_in    = '0;
    ext_irq    = 1'b0;
    core_sleep = 1'b0;
    m_out      = '0;
    m_oe       = '0;
    m_en       = '0;
    m_status   = '0;
    m_prev     = '0;
    m_msip     = 1'b0;
    m_ext      = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("reset_rvalid", '0, data_t'(rvalid));
    check_value("reset_irq", '0, irq);
    check_value("reset_gpio", '0, data_t'({gpio_out, gpio_oe}));
    check_value("reset_power", 32'd4, data_t'({cpu_switch, cpu_iso, cpu_rst}));

    // gpio output and enable registers
    repeat (10) begin
      d = $random(seed);
      bus_write(reg_addr(BLK_GPIO, GPIO_OUT), d);
      m_out = d[NUM_GPIO-1:0];
      @(negedge clk);
      check_value("gpio_o", data_t'(m_out), data_t'(gpio_out));
      d = $random(seed);
      bus_write(reg_addr(BLK_GPIO, GPIO_OE), d);
      m_oe = d[NUM_GPIO-1:0];
      @(negedge clk);
      check_value("gpio_oe_o", data_t'(m_oe), data_t'(gpio_oe));
      read_check("gpio_out_read", reg_addr(BLK_GPIO, GPIO_OUT), data_t'(m_out));
      read_check("gpio_oe_read", reg_addr(BLK_GPIO, GPIO_OE), data_t'(m_oe));
    end
    read_check("gpio_unmapped", reg_addr(BLK_GPIO, 8'h14), '0);
    read_check("timer_unmapped", reg_addr(BLK_TIMER, 8'h0C), '0);
    read_check("irq_unmapped", reg_addr(BLK_IRQ, 8'h08), '0);
    read_check("pwr_unmapped", reg_addr(BLK_PWR, 8'h40), '0);

    // gpio inputs and rising-edge interrupts
    repeat (2) begin
      d = $random(seed);
      bus_write(reg_addr(BLK_GPIO, GPIO_INTR_EN), d);
      m_en = d[NUM_GPIO-1:0];
      repeat (8) begin
        d = $random(seed);
        v = d[NUM_GPIO-1:0];
        @(posedge clk);
        gpio_in <= v;
        m_status = m_status | (v & ~m_prev & m_en);
        m_prev   = v;
        wait_cycles(4);
        check_irq("gpio_irq");
        read_check("gpio_in_read", reg_addr(BLK_GPIO, GPIO_IN), data_t'(v));
        read_check("gpio_status", reg_addr(BLK_GPIO, GPIO_INTR_STATUS), data_t'(m_status));
      end
      bus_write(reg_addr(BLK_GPIO, GPIO_INTR_STATUS), data_t'(m_status));
      m_status = '0;
      wait_cycles(1);
      check_irq("gpio_irq_clear");
      read_check("gpio_status_clear", reg_addr(BLK_GPIO, GPIO_INTR_STATUS), '0);
    end

    // timer compare
    d = $random(seed);
    c = 5 + int'(d % 36);
    bus_write(reg_addr(BLK_TIMER, TMR_TIME), '0);
    bus_write(reg_addr(BLK_TIMER, TMR_CMP), data_t'(c));
    read_check("timer_cmp_read", reg_addr(BLK_TIMER, TMR_CMP), data_t'(c));
    bus_write(reg_addr(BLK_TIMER, TMR_CTRL), 32'd1);
    t_prev = '0;
    n      = 0;
    do begin
      bus_read(reg_addr(BLK_TIMER, TMR_TIME), t);
      n++;
      if (t < t_prev) begin
        check_value("timer_monotonic", t_prev, t);
      end
      if (t < data_t'(c)) begin
        check_value("timer_irq_low", '0, data_t'(irq[7]));
      end
      t_prev = t;
    end while (t < data_t'(c) && n < 100);
    assert (t >= data_t'(c)) else begin
      errors++;
      $display("timer never reached the compare value %0d", c);
    end
    wait_cycles(3);
    check_value("timer_irq_high", 32'd1, data_t'(irq[7]));
    bus_write(reg_addr(BLK_TIMER, TMR_CTRL), '0);
    wait_cycles(2);
    check_irq("timer_irq_off");

    // software and external interrupts
    repeat (6) begin
      d = $random(seed);
      bus_write(reg_addr(BLK_IRQ, IRQ_MSIP), data_t'(d[0]));
      ext_irq <= d[1];
      m_msip = d[0];
      m_ext  = d[1];
      wait_cycles(1);
      check_irq("sw_ext_irq");
      read_check("msip_read", reg_addr(BLK_IRQ, IRQ_MSIP), data_t'(m_msip));
      bus_read(reg_addr(BLK_IRQ, IRQ_VECTOR), d);
      check_value("vector_read", expected_irq(), d);
      check_irq("vector_irq");
    end
    bus_write(reg_addr(BLK_IRQ, IRQ_MSIP), '0);
    ext_irq <= 1'b0;
    m_msip = 1'b0;
    m_ext  = 1'b0;
    wait_cycles(1);
    check_irq("irq_clear");

    // power-down is refused while the core runs
    bus_write(reg_addr(BLK_PWR, PWR_CTRL), 32'd1);
    wait_cycles(2);
    read_check("pwr_refused", reg_addr(BLK_PWR, PWR_STATE), data_t'(PWR_ON));
    check_value("cpu_rst_refused", '0, data_t'(cpu_rst));
    @(posedge clk);
    core_sleep <= 1'b1;
    bus_write(reg_addr(BLK_PWR, PWR_CTRL), 32'd1);
    // one state per cycle up to the switch
    @(negedge clk);
    check_value("down_rst_first", 32'd5, data_t'({cpu_switch, cpu_iso, cpu_rst}));
    @(negedge clk);
    check_value("down_iso_second", 32'd7, data_t'({cpu_switch, cpu_iso, cpu_rst}));
    @(negedge clk);
    check_value("down_switch_off", 32'd3, data_t'({cpu_switch, cpu_iso, cpu_rst}));
    n = 0;
    do begin
      bus_read(reg_addr(BLK_PWR, PWR_STATE), d);
      n++;
    end while (d != data_t'(PWR_OFF) && n < 20);
    check_value("pwr_state_off", data_t'(PWR_OFF), d);
    check_value("switch_ack_off", '0, data_t'(cpu_switch_ack));

    // wake on software interrupt, releases in reverse order
    bus_write(reg_addr(BLK_IRQ, IRQ_MSIP), 32'd1);
    m_msip = 1'b1;
    sw_at  = -1;
    iso_at = -1;
    rst_at = -1;
    for (n = 1; n <= 40 && rst_at < 0; n++) begin
      @(negedge clk);
      if (cpu_switch && sw_at < 0) sw_at = n;
      if (!cpu_iso && iso_at < 0) iso_at = n;
      if (!cpu_rst && rst_at < 0) rst_at = n;
    end
    checks++;
    assert (sw_at > 0 && iso_at > sw_at && rst_at > iso_at) else begin
      errors++;
      $display("wake-up order wrong: switch at %0d, isolation at %0d, reset at %0d",
               sw_at, iso_at, rst_at);
    end
    read_check("pwr_state_on", reg_addr(BLK_PWR, PWR_STATE), data_t'(PWR_ON));
    bus_write(reg_addr(BLK_IRQ, IRQ_MSIP), '0);
    core_sleep <= 1'b0;
    m_msip = 1'b0;
    wait_cycles(1);
    check_irq("irq_after_wake");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
